//--- Makefile
TOP = game_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f game_core.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- game_core.f
hdl/game_pkg.sv
hdl/frame_ticker.sv
hdl/tile_map.sv
hdl/map_arbiter.sv
hdl/char_ctrl.sv
hdl/shot_ctrl.sv
hdl/game_core.sv
test/game_core_tb.sv

//--- hdl/char_ctrl.sv
`timescale 1ns/10ps

module char_ctrl import game_pkg::*; #(
    parameter int SPAWN_X = 128,
    parameter int SPAWN_Y = 200
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     frame,
    input  ctrl_in_t ctrl,

    output logic     req_valid,
    input  logic     req_ready,
    output map_req_t req,
    input  logic     rsp_valid,
    input  logic     rsp_solid,

    output pos_t     pos,
    output logic     flip_h
);
    localparam logic [11:0] LEFT_BOUND  = 12'(CHAR_LNG + MOVE_STEP);
    localparam logic [11:0] RIGHT_BOUND = 12'(HOR_PIXELS - CHAR_LNG - MOVE_STEP);

    char_state_e state;

    logic        jumping;
    logic        jump_q;
    logic [11:0] peak;
    logic [11:0] next_x;
    logic [11:0] foot_x;
    logic [11:0] foot_y;

    // Left wins when both directions are held. A step that would leave the bounds is dropped.
    always_comb begin
        next_x = pos.x;
        if (ctrl.step_left) begin
            if (pos.x >= LEFT_BOUND + 12'(MOVE_STEP)) begin
                next_x = pos.x - 12'(MOVE_STEP);
            end
        end else if (ctrl.step_right) begin
            if (pos.x + 12'(MOVE_STEP) <= RIGHT_BOUND) begin
                next_x = pos.x + 12'(MOVE_STEP);
            end
        end
    end

    assign foot_x = next_x + 12'(CHAR_LNG / 2);
    assign foot_y = pos.y + 12'(CHAR_HGT);

    assign req_valid = (state == CHAR_PROBE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= CHAR_IDLE;
            pos.x   <= 12'(SPAWN_X);
            pos.y   <= 12'(SPAWN_Y);
            flip_h  <= 1'b0;
            jumping <= 1'b0;
            jump_q  <= 1'b0;
            peak    <= '0;
            req     <= '0;
        end else begin
            case (state)
                CHAR_IDLE: begin
                    if (frame) begin
                        if (ctrl.step_left) begin
                            flip_h <= 1'b1;
                        end else if (ctrl.step_right) begin
                            flip_h <= 1'b0;
                        end
                        pos.x   <= next_x;
                        jump_q  <= ctrl.jump;
                        req.col <= foot_x[TILE_SHIFT +: COL_W];  // Tile under the feet.
                        req.row <= foot_y[TILE_SHIFT +: ROW_W];
                        state   <= CHAR_PROBE;
                    end
                end
                CHAR_PROBE: begin
                    if (req_ready) begin
                        state <= CHAR_UPDATE;
                    end
                end
                CHAR_UPDATE: begin
                    if (rsp_valid) begin
                        if (jumping) begin
                            if (pos.y > peak + 12'(JUMP_SPEED)) begin
                                pos.y <= pos.y - 12'(JUMP_SPEED);
                            end else begin
                                jumping <= 1'b0;  // Peak reached.
                            end
                        end else if (!rsp_solid) begin
                            pos.y <= pos.y + 12'(FALL_SPEED);
                        end else if (jump_q) begin
                            jumping <= 1'b1;  // Only from solid ground.
                            peak    <= pos.y - 12'(JUMP_HEIGHT);
                        end
                        state <= CHAR_IDLE;
                    end
                end
                default: state <= CHAR_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/frame_ticker.sv
`timescale 1ns/10ps

module frame_ticker #(
    parameter int FRAME_TICKS = 1_083_333
) (
    input  logic clk,
    input  logic rst,
    output logic frame
);
    localparam int CNT_W = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

    logic [CNT_W-1:0] tick_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            frame    <= 1'b0;
        end else if (tick_cnt == CNT_W'(FRAME_TICKS - 1)) begin
            tick_cnt <= '0;
            frame    <= 1'b1;  // One pulse per wrap.
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            frame    <= 1'b0;
        end
    end

endmodule

//--- hdl/game_core.sv
`timescale 1ns/10ps

module game_core import game_pkg::*; #(
    parameter int FRAME_TICKS = 1_083_333,
    parameter int SPAWN_X     = 128,
    parameter int SPAWN_Y     = 200
) (
    input  logic     clk,
    input  logic     rst,
    input  ctrl_in_t ctrl,

    output logic     frame,
    output pos_t     char_pos,
    output logic     flip_h,
    output pos_t     shot_pos,
    output logic     shot_active
);
    logic     char_req_valid;
    logic     char_req_ready;
    map_req_t char_req;
    logic     char_rsp_valid;
    logic     char_rsp_solid;

    logic     shot_req_valid;
    logic     shot_req_ready;
    map_req_t shot_req;
    logic     shot_rsp_valid;
    logic     shot_rsp_solid;

    map_req_t map_addr;
    logic     map_solid;

    frame_ticker #(
        .FRAME_TICKS(FRAME_TICKS)
    ) u_frame_ticker (
        .clk  (clk),
        .rst  (rst),
        .frame(frame)
    );

    char_ctrl #(
        .SPAWN_X(SPAWN_X),
        .SPAWN_Y(SPAWN_Y)
    ) u_char_ctrl (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .ctrl     (ctrl),
        .req_valid(char_req_valid),
        .req_ready(char_req_ready),
        .req      (char_req),
        .rsp_valid(char_rsp_valid),
        .rsp_solid(char_rsp_solid),
        .pos      (char_pos),
        .flip_h   (flip_h)
    );

    shot_ctrl u_shot_ctrl (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .fire     (ctrl.fire),
        .char_pos (char_pos),
        .flip_h   (flip_h),
        .req_valid(shot_req_valid),
        .req_ready(shot_req_ready),
        .req      (shot_req),
        .rsp_valid(shot_rsp_valid),
        .rsp_solid(shot_rsp_solid),
        .pos      (shot_pos),
        .active   (shot_active)
    );

    // The character uses port a and the shot uses port b.
    map_arbiter u_map_arbiter (
        .clk        (clk),
        .rst        (rst),
        .a_valid    (char_req_valid),
        .a_req      (char_req),
        .a_ready    (char_req_ready),
        .a_rsp_valid(char_rsp_valid),
        .a_rsp_solid(char_rsp_solid),
        .b_valid    (shot_req_valid),
        .b_req      (shot_req),
        .b_ready    (shot_req_ready),
        .b_rsp_valid(shot_rsp_valid),
        .b_rsp_solid(shot_rsp_solid),
        .map_addr   (map_addr),
        .map_solid  (map_solid)
    );

    tile_map u_tile_map (
        .clk  (clk),
        .addr (map_addr),
        .solid(map_solid)
    );

endmodule

//--- hdl/game_pkg.sv
package game_pkg;

    localparam int HOR_PIXELS = 640;
    localparam int VER_PIXELS = 480;

    localparam int TILE_SIZE  = 16;
    localparam int TILE_SHIFT = $clog2(TILE_SIZE);
    localparam int MAP_COLS   = 40;
    localparam int MAP_ROWS   = 30;
    localparam int COL_W      = 6;
    localparam int ROW_W      = 5;

    localparam int CHAR_HGT    = 32;
    localparam int CHAR_LNG    = 24;
    localparam int MOVE_STEP   = 5;
    localparam int FALL_SPEED  = 5;
    localparam int JUMP_SPEED  = 7;
    localparam int JUMP_HEIGHT = 120;
    localparam int SHOT_STEP   = 8;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } pos_t;

    typedef struct packed {
        logic step_left;
        logic step_right;
        logic jump;
        logic fire;
    } ctrl_in_t;

    typedef struct packed {
        logic [COL_W-1:0] col;
        logic [ROW_W-1:0] row;
    } map_req_t;

    typedef enum logic [1:0] {CHAR_IDLE, CHAR_PROBE, CHAR_UPDATE} char_state_e;

    typedef enum logic [1:0] {SHOT_IDLE, SHOT_PROBE, SHOT_UPDATE} shot_state_e;

endpackage

//--- hdl/level.mem
// One tile row per line, 40 columns as 10 hex digits, column 0 is the leftmost bit.
// A set bit is a solid block. Rows 20 to 26 hold the wall at column 30.
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000000
0000000200
0000000200
0000000200
0000000200
0000000200
0000000200
0000000200
FFFFFFFFFF
FFFFFFFFFF
FFFFFFFFFF

//--- hdl/map_arbiter.sv
`timescale 1ns/10ps

module map_arbiter import game_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     a_valid,
    input  map_req_t a_req,
    output logic     a_ready,
    output logic     a_rsp_valid,
    output logic     a_rsp_solid,

    input  logic     b_valid,
    input  map_req_t b_req,
    output logic     b_ready,
    output logic     b_rsp_valid,
    output logic     b_rsp_solid,

    output map_req_t map_addr,
    input  logic     map_solid
);
    logic busy;    // High in the cycle the map reply is returned.
    logic last_b;  // Requester b holds the most recent grant.
    logic grant_a;
    logic grant_b;

    // The requester that was not granted last wins a tie.
    assign grant_a = !busy && a_valid && (!b_valid || last_b);
    assign grant_b = !busy && b_valid && (!a_valid || !last_b);

    assign a_ready = grant_a;
    assign b_ready = grant_b;

    assign map_addr = grant_b ? b_req : a_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            last_b <= 1'b0;
        end else if (busy) begin
            busy <= 1'b0;
        end else if (grant_a || grant_b) begin
            busy   <= 1'b1;
            last_b <= grant_b;
        end
    end

    // The reply goes back to whoever was granted in the previous cycle.
    assign a_rsp_valid = busy && !last_b;
    assign b_rsp_valid = busy && last_b;
    assign a_rsp_solid = map_solid;
    assign b_rsp_solid = map_solid;

endmodule

//--- hdl/shot_ctrl.sv
`timescale 1ns/10ps

module shot_ctrl import game_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     frame,
    input  logic     fire,
    input  pos_t     char_pos,
    input  logic     flip_h,

    output logic     req_valid,
    input  logic     req_ready,
    output map_req_t req,
    input  logic     rsp_valid,
    input  logic     rsp_solid,

    output pos_t     pos,
    output logic     active
);
    shot_state_e state;

    logic        dir_left;
    logic [11:0] cand_x;
    logic [11:0] step_x;
    logic        off_screen;

    assign step_x = dir_left ? pos.x - 12'(SHOT_STEP) : pos.x + 12'(SHOT_STEP);

    // The left edge is crossed when the step would go below zero.
    assign off_screen = dir_left ? (pos.x < 12'(SHOT_STEP))
                                 : (step_x > 12'(HOR_PIXELS - 1));

    assign req_valid = (state == SHOT_PROBE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SHOT_IDLE;
            active   <= 1'b0;
            dir_left <= 1'b0;
            pos      <= '0;
            cand_x   <= '0;
            req      <= '0;
        end else begin
            case (state)
                SHOT_IDLE: begin
                    if (frame) begin
                        if (!active) begin
                            if (fire) begin
                                active   <= 1'b1;
                                dir_left <= flip_h;
                                pos.x    <= char_pos.x + 12'(CHAR_LNG / 2);
                                pos.y    <= char_pos.y + 12'(CHAR_HGT / 2);
                            end
                        end else if (off_screen) begin
                            active <= 1'b0;
                        end else begin
                            cand_x  <= step_x;
                            req.col <= step_x[TILE_SHIFT +: COL_W];
                            req.row <= pos.y[TILE_SHIFT +: ROW_W];
                            state   <= SHOT_PROBE;
                        end
                    end
                end
                SHOT_PROBE: begin
                    if (req_ready) begin
                        state <= SHOT_UPDATE;
                    end
                end
                SHOT_UPDATE: begin
                    if (rsp_valid) begin
                        if (rsp_solid) begin
                            active <= 1'b0;  // Hit a block.
                        end else begin
                            pos.x <= cand_x;
                        end
                        state <= SHOT_IDLE;
                    end
                end
                default: state <= SHOT_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/tile_map.sv
`timescale 1ns/10ps

module tile_map import game_pkg::*; (
    input  logic     clk,
    input  map_req_t addr,
    output logic     solid
);
    // Column 0 is the leftmost hex digit of each row in the data file.
    logic [0:MAP_COLS-1] map_rows [MAP_ROWS];

    logic in_map;

    initial begin
        $readmemh("hdl/level.mem", map_rows);
    end

    assign in_map = (addr.col < COL_W'(MAP_COLS)) && (addr.row < ROW_W'(MAP_ROWS));

    always_ff @(posedge clk) begin
        if (in_map) begin
            solid <= map_rows[addr.row][addr.col];
        end else begin
            solid <= 1'b1;  // Anything off the map counts as a wall.
        end
    end

endmodule

//--- test/game_core_tb.sv
`timescale 1ns/10ps

module game_core_tb import game_pkg::*; ();
    localparam int FRAME_TICKS  = 16;
    localparam int SPAWN_X      = 128;
    localparam int SPAWN_Y      = 200;
    localparam int CLK_PERIOD   = 100;
    localparam int TOTAL_FRAMES = 45 + 160 + 50 + 126 + 33 + 60;  // Sum over all tests.

    logic     clk;
    logic     rst;
    ctrl_in_t ctrl;
    logic     frame;
    pos_t     char_pos;
    logic     flip_h;
    pos_t     shot_pos;
    logic     shot_active;

    logic [0:MAP_COLS-1] map_rows [MAP_ROWS];

    int   errors;
    int   checks;
    int   seed = 32'h2b4d4079;
    time  last_frame;

    // Reference state of the movement rules.
    int   m_x;
    int   m_y;
    logic m_flip;
    logic m_jumping;
    int   m_peak;
    logic m_shot_active;
    logic m_shot_left;
    int   m_shot_x;
    int   m_shot_y;

    game_core #(
        .FRAME_TICKS(FRAME_TICKS),
        .SPAWN_X    (SPAWN_X),
        .SPAWN_Y    (SPAWN_Y)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .frame      (frame),
        .char_pos   (char_pos),
        .flip_h     (flip_h),
        .shot_pos   (shot_pos),
        .shot_active(shot_active)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ctrl_in_t buttons(input logic left, input logic right,
                                         input logic jump, input logic fire);
        ctrl_in_t c;
        c.step_left  = left;
        c.step_right = right;
        c.jump       = jump;
        c.fire       = fire;
        return c;
    endfunction

    function automatic logic tile_solid(input int x, input int y);
        logic [5:0] col;
        logic [4:0] row;
        if (x < 0 || y < 0 || x / TILE_SIZE >= MAP_COLS || y / TILE_SIZE >= MAP_ROWS) begin
            return 1'b1;  // Off the map is a wall.
        end
        col = 6'(x / TILE_SIZE);
        row = 5'(y / TILE_SIZE);
        return map_rows[row][col];
    endfunction

    task automatic apply_model(input ctrl_in_t c);
        int   old_x;
        int   old_y;
        logic old_flip;
        logic foot_solid;
        int   cand;
        old_x    = m_x;
        old_y    = m_y;
        old_flip = m_flip;
        if (c.step_left) begin
            m_flip = 1'b1;
            if (m_x - MOVE_STEP >= CHAR_LNG + MOVE_STEP) m_x = m_x - MOVE_STEP;
        end else if (c.step_right) begin
            m_flip = 1'b0;
            if (m_x + MOVE_STEP <= HOR_PIXELS - CHAR_LNG - MOVE_STEP) m_x = m_x + MOVE_STEP;
        end
        foot_solid = tile_solid(m_x + CHAR_LNG / 2, old_y + CHAR_HGT);
        if (m_jumping) begin
            if (m_y > m_peak + JUMP_SPEED) m_y = m_y - JUMP_SPEED;
            else m_jumping = 1'b0;
        end else if (!foot_solid) begin
            m_y = m_y + FALL_SPEED;
        end else if (c.jump) begin
            m_jumping = 1'b1;
            m_peak    = m_y - JUMP_HEIGHT;
        end
        // The shot sees the character as it was before this frame.
        if (!m_shot_active) begin
            if (c.fire) begin
                m_shot_active = 1'b1;
                m_shot_left   = old_flip;
                m_shot_x      = old_x + CHAR_LNG / 2;
                m_shot_y      = old_y + CHAR_HGT / 2;
            end
        end else begin
            cand = m_shot_left ? m_shot_x - SHOT_STEP : m_shot_x + SHOT_STEP;
            if (cand < 0 || cand > HOR_PIXELS - 1) m_shot_active = 1'b0;
            else if (tile_solid(cand, m_shot_y)) m_shot_active = 1'b0;
            else m_shot_x = cand;
        end
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        check_value("frame", int'(frame), 0);
        check_value("char_pos.x", int'(char_pos.x), m_x);
        check_value("char_pos.y", int'(char_pos.y), m_y);
        check_value("flip_h", int'(flip_h), int'(m_flip));
        check_value("shot_active", int'(shot_active), int'(m_shot_active));
        check_value("shot_pos.x", int'(shot_pos.x), m_shot_x);
        check_value("shot_pos.y", int'(shot_pos.y), m_shot_y);
    endtask

    task automatic frame_step(input ctrl_in_t c);
        @(posedge clk);
        ctrl <= c;
        @(negedge clk);
        while (!frame) begin
            @(negedge clk);
        end
        if (last_frame != 0) begin
            check_value("frame period", int'(($time - last_frame) / CLK_PERIOD), FRAME_TICKS);
        end
        last_frame = $time;
        apply_model(c);
        @(posedge clk);  // The controllers take the frame here.
        repeat (FRAME_TICKS - 1) @(negedge clk);
        check_outputs();
    endtask

    task automatic run_frames(input ctrl_in_t c, input int n);
        repeat (n) frame_step(c);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic reset_and_fall();
        int err_before;
        err_before = errors;
        check_outputs();
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 45);
        report_test("reset and fall", err_before);
    endtask

    task automatic walk_to_edges();
        int err_before;
        err_before = errors;
        run_frames(buttons(1'b1, 1'b0, 1'b0, 1'b0), 30);
        run_frames(buttons(1'b0, 1'b1, 1'b0, 1'b0), 125);
        run_frames(buttons(1'b1, 1'b1, 1'b0, 1'b0), 5);
        report_test("walk to edges", err_before);
    endtask

    task automatic jump_and_land();
        int err_before;
        err_before = errors;
        run_frames(buttons(1'b0, 1'b0, 1'b1, 1'b0), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 4);
        run_frames(buttons(1'b0, 1'b0, 1'b1, 1'b0), 4);  // Pressed in mid-air.
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 41);
        report_test("jump and land", err_before);
    endtask

    task automatic shot_right();
        int err_before;
        err_before = errors;
        run_frames(buttons(1'b1, 1'b0, 1'b0, 1'b0), 80);
        run_frames(buttons(1'b0, 1'b1, 1'b0, 1'b0), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b1), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 9);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b1), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 34);
        report_test("shot right", err_before);
    endtask

    task automatic shot_left();
        int err_before;
        err_before = errors;
        run_frames(buttons(1'b1, 1'b0, 1'b0, 1'b0), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b1), 1);
        run_frames(buttons(1'b0, 1'b0, 1'b0, 1'b0), 31);
        report_test("shot left", err_before);
    endtask

    task automatic mixed_contention();
        int          err_before;
        logic [31:0] rnd;
        err_before = errors;
        run_frames(buttons(1'b0, 1'b1, 1'b1, 1'b1), 4);
        repeat (56) begin
            rnd = $random(seed);
            frame_step(buttons(rnd[0], rnd[1], rnd[2], rnd[3]));
        end
        report_test("contention", err_before);
    endtask

    initial begin
        #((TOTAL_FRAMES + 20) * FRAME_TICKS * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        ctrl          = '0;
        errors        = 0;
        checks        = 0;
        last_frame    = 0;
        m_x           = SPAWN_X;
        m_y           = SPAWN_Y;
        m_flip        = 1'b0;
        m_jumping     = 1'b0;
        m_peak        = 0;
        m_shot_active = 1'b0;
        m_shot_left   = 1'b0;
        m_shot_x      = 0;
        m_shot_y      = 0;
        $readmemh("hdl/level.mem", map_rows);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_and_fall();
        walk_to_edges();
        jump_and_land();
        shot_right();
        shot_left();
        mixed_contention();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
